// ==== Bender.yml ====
package:
  name: gpio_periph

sources:
  # Packages come first, the blocks import them
  - src/periph_map_pkg.sv
  - src/periph_cfg_pkg.sv
  - src/hwrng_fifo.sv
  - src/spi_dword_master.sv
  - src/periph_reg_bus.sv
  - src/gpio_periph_top.sv
  - target: test
    files:
      - bench/gpio_periph_assertions.sv
      - bench/gpio_periph_tb.sv

// ==== bench/gpio_periph_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

// Protocol checks for the register bus and the SPI master
module gpio_periph_assertions (
    input logic                                clk_i,
    input logic                                reset_i,
    input logic                                pop_i,
    input logic                                start_i,
    input logic [periph_map_pkg::LedWidth-1:0] leds_i,
    input logic                                busy_i,
    input logic                                csn_i
);

    int fail_count = 0;   // Failed assertion attempts

    // Write decode pulses
    pop_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i) pop_i |=> !pop_i)
        else
        begin
            $error("pop pulse lasted longer than one cycle");
            fail_count++;
        end
    start_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i) start_i |=> !start_i)
        else
        begin
            $error("start pulse lasted longer than one cycle");
            fail_count++;
        end

    // Chip select released whenever idle
    csn_when_idle: assert property (@(posedge clk_i) disable iff (reset_i) !busy_i |-> csn_i)
        else
        begin
            $error("csn low while the SPI master is idle");
            fail_count++;
        end

    reset_values: assert property (@(posedge clk_i) $fell(reset_i) |-> (!busy_i && leds_i == '0))
        else
        begin
            $error("busy or LEDs not cleared by reset");
            fail_count++;
        end

endmodule

// Pulses and LEDs come from the register bus, busy and csn from the SPI master
bind gpio_periph_top gpio_periph_assertions protocol_checks (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .pop_i   ( rng_pop   ),
    .start_i ( spi_start ),
    .leds_i  ( leds_o    ),
    .busy_i  ( spi_busy  ),
    .csn_i   ( spi_csn_o )
);

`default_nettype wire

// ==== bench/gpio_periph_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpio_periph_tb;

    import periph_map_pkg::*;
    import periph_cfg_pkg::*;

    localparam int TableLen      = 8;
    localparam int SpiTransfers  = 3;
    localparam int TimeoutCycles = TableLen * 4 + FifoDepth * RngPeriod * 3
                                 + SpiTransfers * (SpiBits * 2 * SpiHalfPeriod + 20);

    logic                 clk_i;
    logic                 reset_i;
    logic                 req_i;
    logic                 we_i;
    logic [AddrWidth-1:0] addr_i;
    logic [DataWidth-1:0] wdata_i;
    logic [LedWidth-1:0]  dip_switches_i;
    logic                 spi_miso_i;
    logic [DataWidth-1:0] rdata_o;
    logic [LedWidth-1:0]  leds_o;
    logic                 spi_sclk_o;
    logic                 spi_csn_o;
    logic                 spi_mosi_o;

    integer seed;
    int     cycle_count;

    // Stimulus table
    logic                 tbl_write  [TableLen];
    reg_sel_t             tbl_sel    [TableLen];
    logic [DataWidth-1:0] tbl_wdata  [TableLen];
    logic [LedWidth-1:0]  tbl_dip    [TableLen];
    logic [DataWidth-1:0] tbl_expect [TableLen];   // Read data, or LEDs for a write

    // SPI slave model
    logic [SpiBits-1:0]   slave_tx_word;            // Word for the next transfer
    logic [SpiBits-1:0]   slave_tx_q;
    logic [SpiBits-1:0]   slave_rx_q;

    gpio_periph_top UUT (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .req_i          ( req_i          ),
        .we_i           ( we_i           ),
        .addr_i         ( addr_i         ),
        .wdata_i        ( wdata_i        ),
        .dip_switches_i ( dip_switches_i ),
        .spi_miso_i     ( spi_miso_i     ),
        .rdata_o        ( rdata_o        ),
        .leds_o         ( leds_o         ),
        .spi_sclk_o     ( spi_sclk_o     ),
        .spi_csn_o      ( spi_csn_o      ),
        .spi_mosi_o     ( spi_mosi_o     )
    );

    initial
    begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TimeoutCycles)
        begin
            $display("Timeout after %0d cycles, the test sequence did not complete",
                     cycle_count);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // Failures of the bound protocol assertions
    always @(negedge clk_i)
    begin
        assert (UUT.protocol_checks.fail_count == 0)
        else
        begin
            $display("A protocol assertion failed, see the error report above");
            $display("Verification failed");
            $fatal(1);
        end
    end

    // ------------------------------
    // SPI slave, mode 0
    // ------------------------------
    always @(negedge spi_csn_o)
    begin
        slave_tx_q <= slave_tx_word;
        spi_miso_i <= slave_tx_word[SpiBits-1];  // First bit before any sclk edge
    end

    always @(negedge spi_sclk_o)
    begin
        if (!spi_csn_o)
        begin
            slave_tx_q <= slave_tx_q << 1;
            spi_miso_i <= slave_tx_q[SpiBits-2];
        end
    end

    always @(posedge spi_sclk_o)
        slave_rx_q <= {slave_rx_q[SpiBits-2:0], spi_mosi_o};

    // ------------------------------
    // Helpers
    // ------------------------------
    // Right-shifting Galois LFSR
    function automatic logic [RngWidth-1:0] lfsr_step(input logic [RngWidth-1:0] value);
        if (value[0])
            return (value >> 1) ^ LfsrTaps;
        return value >> 1;
    endfunction

    task automatic expect_equal(input string name, input logic [DataWidth-1:0] actual,
                                input logic [DataWidth-1:0] expected);
        assert (actual === expected)
        else
        begin
            $display("ERROR: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // One request, read data taken in the following cycle
    task automatic bus_access(input logic write, input reg_sel_t sel,
                              input logic [DataWidth-1:0] data,
                              output logic [DataWidth-1:0] rd);
        @(posedge clk_i);
        req_i   <= 1'b1;
        we_i    <= write;
        addr_i  <= AddrWidth'(sel) << RegSelLsb;
        wdata_i <= data;
        @(posedge clk_i);
        req_i   <= 1'b0;
        we_i    <= 1'b0;
        @(negedge clk_i);
        rd = rdata_o;
    endtask

    task automatic set_entry(input int idx, input logic write, input reg_sel_t sel,
                             input logic [DataWidth-1:0] data, input logic [LedWidth-1:0] dip,
                             input logic [DataWidth-1:0] expected);
        tbl_write[idx]  = write;
        tbl_sel[idx]    = sel;
        tbl_wdata[idx]  = data;
        tbl_dip[idx]    = dip;
        tbl_expect[idx] = expected;
    endtask

    task automatic build_table();
        logic [DataWidth-1:0] word;
        logic [LedWidth-1:0]  dip_a;
        logic [LedWidth-1:0]  dip_b;
        word  = $random(seed);
        dip_a = LedWidth'($random(seed));
        dip_b = LedWidth'($random(seed));
        //        write  select         write data     DIP    expected
        set_entry(0, 1'b1, RegLeds,       32'h0000_00A5, 8'h00, 32'h0000_00A5);
        set_entry(1, 1'b0, RegLeds,       '0,            dip_a, DataWidth'(dip_a));
        set_entry(2, 1'b1, RegLeds,       word,          dip_a, DataWidth'(word[LedWidth-1:0]));
        set_entry(3, 1'b0, RegLeds,       '0,            dip_b, DataWidth'(dip_b));
        set_entry(4, 1'b0, reg_sel_t'(1), '0,            dip_b, ReadErrorCode);
        set_entry(5, 1'b0, reg_sel_t'(7), '0,            dip_b, ReadErrorCode);
        set_entry(6, 1'b1, reg_sel_t'(7), ~word,         dip_b, DataWidth'(word[LedWidth-1:0]));
        set_entry(7, 1'b0, RegLeds,       '0,            8'h00, 32'h0);
    endtask

    // ------------------------------
    // Test sequences
    // ------------------------------
    task automatic run_table();
        logic [DataWidth-1:0] rd;
        for (int i = 0; i < TableLen; i++)
        begin
            @(posedge clk_i);
            dip_switches_i <= tbl_dip[i];
            bus_access(tbl_write[i], tbl_sel[i], tbl_wdata[i], rd);
            if (tbl_write[i])
                expect_equal("leds_o", DataWidth'(leds_o), tbl_expect[i]);
            else
                expect_equal("rdata_o", rd, tbl_expect[i]);
        end
    endtask

    task automatic wait_rng_full();
        logic [DataWidth-1:0] status;
        logic [DataWidth-1:0] later;
        status = '0;
        while (!status[31])
            bus_access(1'b0, RegRngStatus, '0, status);
        expect_equal("rng wr_count", DataWidth'(status[FifoCountWidth-1:0]),
                     DataWidth'(FifoDepth));
        expect_equal("rng empty", DataWidth'(status[30]), 32'd0);
        repeat (2 * RngPeriod) @(posedge clk_i);   // At least one push while full
        bus_access(1'b0, RegRngStatus, '0, later);
        expect_equal("rng wrerr", DataWidth'(later[28]), 32'd1);
        expect_equal("rng wr_count", DataWidth'(later[FifoCountWidth-1:0]),
                     DataWidth'(FifoDepth));
    endtask

    task automatic drain_rng();
        logic [RngWidth-1:0]       model;
        logic [DataWidth-1:0]      rd;
        logic [DataWidth-1:0]      status;
        logic [FifoCountWidth-1:0] occupancy;
        logic [FifoCountWidth-1:0] prev_wr;
        logic                      have_prev;
        logic                      synced;
        model = LfsrSeed;
        for (int i = 0; i < FifoDepth; i++)
        begin
            bus_access(1'b0, RegRngData, '0, rd);
            expect_equal("rng head", rd, model);
            model = lfsr_step(model);
            bus_access(1'b1, RegRngData, '0, rd);
            bus_access(1'b0, RegRngStatus, '0, status);
            expect_equal("rng rd_count", DataWidth'(status[16 +: FifoCountWidth]),
                         DataWidth'(i + 1));
        end

        // Keep popping until a push lands on an empty FIFO
        have_prev = 1'b0;
        synced    = 1'b0;
        prev_wr   = '0;
        while (!synced)
        begin
            bus_access(1'b0, RegRngStatus, '0, status);
            occupancy = status[FifoCountWidth-1:0] - status[16 +: FifoCountWidth];
            if (have_prev && occupancy == 1 && status[FifoCountWidth-1:0] != prev_wr)
                synced = 1'b1;
            else if (occupancy != 0)
            begin
                bus_access(1'b1, RegRngData, '0, rd);   // Returns the popped head
                expect_equal("rng head", rd, model);
                model     = lfsr_step(model);
                have_prev = 1'b0;
            end
            else
            begin
                prev_wr   = status[FifoCountWidth-1:0];
                have_prev = 1'b1;
            end
        end

        // Next push is at least seven cycles away
        bus_access(1'b1, RegRngData, '0, rd);
        expect_equal("rng head", rd, model);
        bus_access(1'b1, RegRngData, '0, rd);   // Pop on empty
        bus_access(1'b0, RegRngStatus, '0, status);
        expect_equal("rng rderr", DataWidth'(status[29]), 32'd1);
        expect_equal("rng empty", DataWidth'(status[30]), 32'd1);
    endtask

    task automatic wait_spi_idle(output logic [DataWidth-1:0] status);
        status = 32'h2;
        while (status[1])
            bus_access(1'b0, RegSpiStatus, '0, status);
    endtask

    task automatic spi_single_transfer();
        logic [DataWidth-1:0] word;
        logic [DataWidth-1:0] rd;
        word          = $random(seed);
        slave_tx_word = $random(seed);
        bus_access(1'b1, RegSpiWrite, word, rd);
        wait_spi_idle(rd);
        expect_equal("spi status", rd, 32'h0);
        expect_equal("slave mosi word", slave_rx_q, word);
        bus_access(1'b0, RegSpiReadout, '0, rd);
        expect_equal("spi readout", rd, slave_tx_word);
    endtask

    task automatic spi_busy_restart();
        logic [DataWidth-1:0] first;
        logic [DataWidth-1:0] second;
        logic [DataWidth-1:0] rd;
        first         = $random(seed);
        slave_tx_word = $random(seed);
        bus_access(1'b1, RegSpiWrite, first, rd);
        bus_access(1'b1, RegSpiWrite, ~first, rd);   // Lands while busy
        bus_access(1'b0, RegSpiStatus, '0, rd);
        expect_equal("spi status", rd, 32'h3);
        wait_spi_idle(rd);
        expect_equal("spi status", rd, 32'h1);       // Error held after the transfer
        expect_equal("slave mosi word", slave_rx_q, first);
        bus_access(1'b0, RegSpiReadout, '0, rd);
        expect_equal("spi readout", rd, slave_tx_word);

        second        = $random(seed);
        slave_tx_word = $random(seed);
        bus_access(1'b1, RegSpiWrite, second, rd);
        bus_access(1'b0, RegSpiStatus, '0, rd);
        expect_equal("spi status", rd, 32'h2);       // Busy again, error gone
        wait_spi_idle(rd);
        expect_equal("slave mosi word", slave_rx_q, second);
        bus_access(1'b0, RegSpiReadout, '0, rd);
        expect_equal("spi readout", rd, slave_tx_word);
    endtask

    initial
    begin
        seed           = 15;
        cycle_count    = 0;
        reset_i        = 1'b1;
        req_i          = 1'b0;
        we_i           = 1'b0;
        addr_i         = '0;
        wdata_i        = '0;
        dip_switches_i = '0;
        spi_miso_i     = 1'b0;
        slave_tx_word  = '0;
        build_table();
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;

        run_table();
        wait_rng_full();
        drain_rng();
        spi_single_transfer();
        spi_busy_restart();

        if (UUT.protocol_checks.fail_count == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            $display("A protocol assertion failed, see the error report above");
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/periph_map_pkg.sv
src/periph_cfg_pkg.sv
src/hwrng_fifo.sv
src/spi_dword_master.sv
src/periph_reg_bus.sv
src/gpio_periph_top.sv
bench/gpio_periph_assertions.sv
bench/gpio_periph_tb.sv

// ==== src/gpio_periph_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpio_periph_top (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 req_i,
    input  logic                                 we_i,
    input  logic [periph_map_pkg::AddrWidth-1:0] addr_i,
    input  logic [periph_map_pkg::DataWidth-1:0] wdata_i,
    input  logic [periph_map_pkg::LedWidth-1:0]  dip_switches_i,
    input  logic                                 spi_miso_i,
    output logic [periph_map_pkg::DataWidth-1:0] rdata_o,
    output logic [periph_map_pkg::LedWidth-1:0]  leds_o,
    output logic                                 spi_sclk_o,
    output logic                                 spi_csn_o,
    output logic                                 spi_mosi_o
);

    import periph_map_pkg::*;
    import periph_cfg_pkg::*;

    // RNG FIFO status
    logic                      rng_pop;
    logic [DataWidth-1:0]      rng_head;
    logic                      rng_full;
    logic                      rng_empty;
    logic                      rng_rderr;
    logic                      rng_wrerr;
    logic [FifoCountWidth-1:0] rng_rd_count;
    logic [FifoCountWidth-1:0] rng_wr_count;

    // SPI master
    logic                      spi_start;
    logic [DataWidth-1:0]      spi_start_data;
    logic                      spi_busy;
    logic                      spi_error;
    logic [DataWidth-1:0]      spi_readout;

    hwrng_fifo i_rng (
        .clk_i      ( clk_i        ),
        .reset_i    ( reset_i      ),
        .pop_i      ( rng_pop      ),
        .head_o     ( rng_head     ),
        .full_o     ( rng_full     ),
        .empty_o    ( rng_empty    ),
        .rderr_o    ( rng_rderr    ),
        .wrerr_o    ( rng_wrerr    ),
        .rd_count_o ( rng_rd_count ),
        .wr_count_o ( rng_wr_count )
    );

    spi_dword_master i_spi (
        .clk_i        ( clk_i          ),
        .reset_i      ( reset_i        ),
        .start_i      ( spi_start      ),
        .start_data_i ( spi_start_data ),
        .miso_i       ( spi_miso_i     ),
        .busy_o       ( spi_busy       ),
        .error_o      ( spi_error      ),
        .readout_o    ( spi_readout    ),
        .sclk_o       ( spi_sclk_o     ),
        .csn_o        ( spi_csn_o      ),
        .mosi_o       ( spi_mosi_o     )
    );

    periph_reg_bus i_reg_bus (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .req_i          ( req_i          ),
        .we_i           ( we_i           ),
        .addr_i         ( addr_i         ),
        .wdata_i        ( wdata_i        ),
        .dip_switches_i ( dip_switches_i ),
        .rng_head_i     ( rng_head       ),
        .rng_full_i     ( rng_full       ),
        .rng_empty_i    ( rng_empty      ),
        .rng_rderr_i    ( rng_rderr      ),
        .rng_wrerr_i    ( rng_wrerr      ),
        .rng_rd_count_i ( rng_rd_count   ),
        .rng_wr_count_i ( rng_wr_count   ),
        .spi_busy_i     ( spi_busy       ),
        .spi_error_i    ( spi_error      ),
        .spi_readout_i  ( spi_readout    ),
        .rdata_o        ( rdata_o        ),
        .leds_o         ( leds_o         ),
        .pop_o          ( rng_pop        ),
        .start_o        ( spi_start      ),
        .start_data_o   ( spi_start_data )
    );

endmodule

`default_nettype wire

// ==== src/hwrng_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module hwrng_fifo (
    input  logic                                      clk_i,
    input  logic                                      reset_i,
    input  logic                                      pop_i,      // Drop head entry
    output logic [periph_cfg_pkg::RngWidth-1:0]       head_o,
    output logic                                      full_o,
    output logic                                      empty_o,
    output logic                                      rderr_o,    // Sticky
    output logic                                      wrerr_o,    // Sticky
    output logic [periph_cfg_pkg::FifoCountWidth-1:0] rd_count_o,
    output logic [periph_cfg_pkg::FifoCountWidth-1:0] wr_count_o
);

    import periph_cfg_pkg::*;

    // ------------------------------
    // Random source
    // ------------------------------
    logic [RngPeriodWidth-1:0] period_q;
    logic                      push_tick;
    logic [RngWidth-1:0]       lfsr_q;
    logic [RngWidth-1:0]       lfsr_next;

    // ------------------------------
    // FIFO state
    // ------------------------------
    logic [RngWidth-1:0]       mem_q [FifoDepth];
    logic [FifoPtrWidth-1:0]   wr_ptr_q;
    logic [FifoPtrWidth-1:0]   rd_ptr_q;
    logic [FifoPtrWidth:0]     fill_q;
    logic [FifoCountWidth-1:0] wr_count_q;
    logic [FifoCountWidth-1:0] rd_count_q;
    logic                      rderr_q;
    logic                      wrerr_q;
    logic                      full;
    logic                      empty;
    logic                      push_ok;
    logic                      pop_ok;

    assign push_tick = (period_q == RngPeriodWidth'(RngPeriod - 1));

    // Taps go in when the dropped bit is set
    assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ LfsrTaps) : (lfsr_q >> 1);

    assign full    = (fill_q == (FifoPtrWidth + 1)'(FifoDepth));
    assign empty   = (fill_q == '0);
    assign push_ok = push_tick && !full;
    assign pop_ok  = pop_i && !empty;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            period_q   <= '0;
            lfsr_q     <= LfsrSeed;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            fill_q     <= '0;
            wr_count_q <= '0;
            rd_count_q <= '0;
            rderr_q    <= 1'b0;
            wrerr_q    <= 1'b0;
        end
        else
        begin
            if (push_tick)
                period_q <= '0;
            else
                period_q <= period_q + 1'b1;

            // Generator only advances on an accepted push
            if (push_ok)
            begin
                lfsr_q     <= lfsr_next;
                wr_ptr_q   <= wr_ptr_q + 1'b1;
                wr_count_q <= wr_count_q + 1'b1;
            end

            if (pop_ok)
            begin
                rd_ptr_q   <= rd_ptr_q + 1'b1;
                rd_count_q <= rd_count_q + 1'b1;
            end

            case ({push_ok, pop_ok})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: ;
            endcase

            if (push_tick && full)
                wrerr_q <= 1'b1;   // Overflow, word dropped
            if (pop_i && empty)
                rderr_q <= 1'b1;   // Underflow
        end
    end

    // Storage
    always_ff @(posedge clk_i)
    begin
        if (push_ok)
            mem_q[wr_ptr_q] <= lfsr_q;
    end

    assign head_o     = mem_q[rd_ptr_q];
    assign full_o     = full;
    assign empty_o    = empty;
    assign rderr_o    = rderr_q;
    assign wrerr_o    = wrerr_q;
    assign rd_count_o = rd_count_q;
    assign wr_count_o = wr_count_q;

endmodule

`default_nettype wire

// ==== src/periph_cfg_pkg.sv ====
`default_nettype none

// Timing and sizing of the RNG FIFO and the SPI master
package periph_cfg_pkg;

    // ------------------------------
    // Random source and FIFO
    // ------------------------------
    localparam int FifoDepth      = 16;
    localparam int FifoPtrWidth   = $clog2(FifoDepth);
    localparam int FifoCountWidth = 9;  // Counters wrap at 512
    localparam int RngWidth       = 32;
    localparam int RngPeriod      = 8;  // Cycles between push attempts
    localparam int RngPeriodWidth = $clog2(RngPeriod + 1);

    // Galois LFSR, right shift
    localparam logic [RngWidth-1:0] LfsrSeed = 32'hACE1_ACE1;
    localparam logic [RngWidth-1:0] LfsrTaps = 32'h8020_0003;

    // ------------------------------
    // SPI master
    // ------------------------------
    localparam int SpiHalfPeriod = 2;   // Clock cycles per sclk phase
    localparam int SpiDivWidth   = $clog2(SpiHalfPeriod + 1);
    localparam int SpiBits       = 32;
    localparam int SpiBitWidth   = $clog2(SpiBits);

endpackage

`default_nettype wire

// ==== src/periph_map_pkg.sv ====
`default_nettype none

// Register map and bus geometry of the GPIO block
package periph_map_pkg;

    // Bus geometry
    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;
    localparam int LedWidth  = 8;

    // Register select field within the byte address
    localparam int RegSelLsb = 3;
    localparam int RegSelMsb = 5;

    typedef logic [RegSelMsb-RegSelLsb:0] reg_sel_t;

    localparam reg_sel_t RegLeds       = 3'd0; // W: LEDs, R: DIP switches
    localparam reg_sel_t RegRngData    = 3'd2; // R: FIFO head, W: pop
    localparam reg_sel_t RegRngStatus  = 3'd3;
    localparam reg_sel_t RegSpiReadout = 3'd4;
    localparam reg_sel_t RegSpiWrite   = 3'd5; // W: start transfer
    localparam reg_sel_t RegSpiStatus  = 3'd6;

    // Returned for every unmapped select
    localparam logic [DataWidth-1:0] ReadErrorCode = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

// ==== src/periph_reg_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_reg_bus (
    input  logic                                      clk_i,
    input  logic                                      reset_i,
    input  logic                                      req_i,
    input  logic                                      we_i,
    input  logic [periph_map_pkg::AddrWidth-1:0]      addr_i,
    input  logic [periph_map_pkg::DataWidth-1:0]      wdata_i,
    input  logic [periph_map_pkg::LedWidth-1:0]       dip_switches_i,
    // RNG FIFO
    input  logic [periph_map_pkg::DataWidth-1:0]      rng_head_i,
    input  logic                                      rng_full_i,
    input  logic                                      rng_empty_i,
    input  logic                                      rng_rderr_i,
    input  logic                                      rng_wrerr_i,
    input  logic [periph_cfg_pkg::FifoCountWidth-1:0] rng_rd_count_i,
    input  logic [periph_cfg_pkg::FifoCountWidth-1:0] rng_wr_count_i,
    // SPI master
    input  logic                                      spi_busy_i,
    input  logic                                      spi_error_i,
    input  logic [periph_map_pkg::DataWidth-1:0]      spi_readout_i,
    output logic [periph_map_pkg::DataWidth-1:0]      rdata_o,
    output logic [periph_map_pkg::LedWidth-1:0]       leds_o,
    output logic                                      pop_o,
    output logic                                      start_o,
    output logic [periph_map_pkg::DataWidth-1:0]      start_data_o
);

    import periph_map_pkg::*;

    reg_sel_t req_sel;
    reg_sel_t rd_sel_q;   // Select of the previous request
    logic     wr_req;

    assign req_sel = addr_i[RegSelMsb:RegSelLsb];
    assign wr_req  = req_i && we_i;

    // ------------------------------
    // Write decode
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            rd_sel_q <= RegLeds;
            leds_o   <= '0;
            pop_o    <= 1'b0;
            start_o  <= 1'b0;
        end
        else
        begin
            pop_o   <= 1'b0;
            start_o <= 1'b0;
            if (req_i)
                rd_sel_q <= req_sel;
            if (wr_req)
            begin
                case (req_sel)
                    RegLeds:     leds_o  <= wdata_i[LedWidth-1:0];
                    RegRngData:  pop_o   <= 1'b1;
                    RegSpiWrite: start_o <= 1'b1;
                    default:     ;
                endcase
            end
        end
    end

    // Word handed to the SPI master with the start pulse
    always_ff @(posedge clk_i)
    begin
        if (wr_req && req_sel == RegSpiWrite)
            start_data_o <= wdata_i;
    end

    // ------------------------------
    // Read data, one cycle after request
    // ------------------------------
    always_comb
    begin
        rdata_o = ReadErrorCode;
        case (rd_sel_q)
            RegLeds:       rdata_o = DataWidth'(dip_switches_i);
            RegRngData:    rdata_o = rng_head_i;
            RegRngStatus:
            begin
                rdata_o     = '0;
                rdata_o[31] = rng_full_i;
                rdata_o[30] = rng_empty_i;
                rdata_o[29] = rng_rderr_i;
                rdata_o[28] = rng_wrerr_i;
                rdata_o[16 +: $bits(rng_rd_count_i)] = rng_rd_count_i;
                rdata_o[0 +: $bits(rng_wr_count_i)]  = rng_wr_count_i;
            end
            RegSpiReadout: rdata_o = spi_readout_i;
            RegSpiStatus:
            begin
                rdata_o    = '0;
                rdata_o[1] = spi_busy_i;
                rdata_o[0] = spi_error_i;
            end
            default:       ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/spi_dword_master.sv ====
`timescale 1ns/1ns
`default_nettype none

// One 32-bit full-duplex transfer per start, SPI mode 0, MSB first
module spi_dword_master (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic                               start_i,
    input  logic [periph_cfg_pkg::SpiBits-1:0] start_data_i,
    input  logic                               miso_i,
    output logic                               busy_o,
    output logic                               error_o,
    output logic [periph_cfg_pkg::SpiBits-1:0] readout_o,
    output logic                               sclk_o,
    output logic                               csn_o,
    output logic                               mosi_o
);

    import periph_cfg_pkg::*;

    logic                   busy_q;
    logic                   error_q;
    logic                   sclk_q;
    logic                   mosi_q;
    logic [SpiDivWidth-1:0] div_q;
    logic [SpiBitWidth-1:0] bit_q;
    logic [SpiBits-1:0]     shift_q;
    logic [SpiBits-1:0]     readout_q;
    logic                   half_done;
    logic                   last_bit;
    logic                   accept;

    assign half_done = (div_q == SpiDivWidth'(SpiHalfPeriod - 1));
    assign last_bit  = (bit_q == SpiBitWidth'(SpiBits - 1));
    assign accept    = start_i && !busy_q;

    // ------------------------------
    // Sequencing
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            busy_q  <= 1'b0;
            error_q <= 1'b0;
            sclk_q  <= 1'b0;
            mosi_q  <= 1'b0;
            div_q   <= '0;
            bit_q   <= '0;
        end
        else
        begin
            if (start_i && busy_q)
                error_q <= 1'b1;   // Start ignored mid-transfer

            if (accept)
            begin
                busy_q  <= 1'b1;
                error_q <= 1'b0;
                sclk_q  <= 1'b0;
                mosi_q  <= start_data_i[SpiBits-1];
                div_q   <= '0;
                bit_q   <= '0;
            end
            else if (busy_q && half_done)
            begin
                div_q  <= '0;
                sclk_q <= ~sclk_q;
                if (sclk_q)   // Falling edge, next bit onto mosi
                begin
                    if (last_bit)
                    begin
                        busy_q <= 1'b0;
                        mosi_q <= 1'b0;
                    end
                    else
                    begin
                        bit_q  <= bit_q + 1'b1;
                        mosi_q <= shift_q[SpiBits-1];
                    end
                end
            end
            else if (busy_q)
                div_q <= div_q + 1'b1;
        end
    end

    // ------------------------------
    // Data path
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (accept)
            shift_q <= start_data_i;
        else if (busy_q && half_done && !sclk_q)
            shift_q <= {shift_q[SpiBits-2:0], miso_i}; // Sample on rising sclk

        // Last falling edge, all miso bits are in
        if (busy_q && half_done && sclk_q && last_bit)
            readout_q <= shift_q;
    end

    assign busy_o    = busy_q;
    assign error_o   = error_q;
    assign readout_o = readout_q;
    assign sclk_o    = sclk_q;
    assign csn_o     = ~busy_q;
    assign mosi_o    = mosi_q;

endmodule

`default_nettype wire
